// File: spmv_pkg.sv
package spmv_pkg;

  // Q1.7 value, weight and result width
  localparam int DATA_W = 8;
  // column index and row length wide enough for 1433 columns
  localparam int COL_W = 11;

  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;

  // header view of the payload
  typedef struct packed {
    logic [DATA_W-1:0] pad;
    logic [COL_W-1:0]  row_len;
  } csr_hdr_t;

  // entry view of the payload
  typedef struct packed {
    logic [COL_W-1:0]  col;
    logic [DATA_W-1:0] value;
  } csr_ent_t;

  typedef union packed {
    csr_hdr_t hdr;
    csr_ent_t ent;
  } csr_payload_u;

  // FIFO data type
  typedef struct packed {
    logic         is_header;
    csr_payload_u payload;
  } csr_word_t;

  // master-driven side of the host bus
  typedef struct packed {
    logic                   awvalid;
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   wvalid;
    logic [AXIL_DATA_W-1:0] wdata;
    logic                   bready;
    logic                   arvalid;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   rready;
  } axil_req_t;

  // slave-driven side of the host bus with OKAY-only responses
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
  } axil_rsp_t;

  // register map
  localparam logic [AXIL_ADDR_W-1:0] REG_WADDR  = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_WDATA  = 8'h04;
  localparam logic [AXIL_ADDR_W-1:0] REG_HEADER = 8'h08;
  localparam logic [AXIL_ADDR_W-1:0] REG_ENTRY  = 8'h0C;
  localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 8'h10;
  localparam logic [AXIL_ADDR_W-1:0] REG_RESULT = 8'h14;

  // field positions inside REG_ENTRY
  localparam int ENT_COL_LSB = 16;
  localparam int ENT_VAL_LSB = 0;

  // REG_STATUS bits
  localparam int STAT_RES_VALID = 0;
  localparam int STAT_FIFO_FULL = 1;

endpackage

// File: spmv_host_port.sv
`timescale 1ns/10ps
module spmv_host_port #(
  parameter int DOT_SIZE = 1433
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  spmv_pkg::axil_req_t           axil_req_i,
  output spmv_pkg::axil_rsp_t           axil_rsp_o,
  output logic                          w_we_o,
  output logic [spmv_pkg::COL_W-1:0]    w_addr_o,
  output logic [spmv_pkg::DATA_W-1:0]   w_data_o,
  output spmv_pkg::csr_word_t           word_o,
  output logic                          push_o,
  input  logic                          fifo_full_i,
  input  logic                          res_valid_i,
  input  logic [spmv_pkg::DATA_W-1:0]   res_data_i,
  output logic                          res_ready_o
);

  logic                               wr_stream;
  logic                               wr_fire;
  logic                               rd_fire;
  logic                               bvalid_q;
  logic                               rvalid_q;
  logic [spmv_pkg::AXIL_DATA_W-1:0]   rdata_q;
  logic [spmv_pkg::AXIL_DATA_W-1:0]   rd_mux;
  logic [spmv_pkg::COL_W-1:0]         waddr_q;
  logic                               res_vld_q;
  logic [spmv_pkg::DATA_W-1:0]        res_q;

  // header and entry writes need room in the FIFO
  assign wr_stream = (axil_req_i.awaddr == spmv_pkg::REG_HEADER) ||
                     (axil_req_i.awaddr == spmv_pkg::REG_ENTRY);

  // AW and W are taken together with one write outstanding at a time
  assign wr_fire = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q &&
                   !(wr_stream && fifo_full_i);

  assign rd_fire = axil_req_i.arvalid && !rvalid_q;

  assign axil_rsp_o.awready = wr_fire;
  assign axil_rsp_o.wready  = wr_fire;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.arready = rd_fire;
  assign axil_rsp_o.rvalid  = rvalid_q;
  assign axil_rsp_o.rdata   = rdata_q;

  // weight memory write port
  assign w_we_o   = wr_fire && (axil_req_i.awaddr == spmv_pkg::REG_WDATA);
  assign w_addr_o = waddr_q;
  assign w_data_o = axil_req_i.wdata[spmv_pkg::DATA_W-1:0];

  assign push_o = wr_fire && wr_stream;

  // same payload bits under two decodings
  always_comb begin
    word_o = '0;
    if (axil_req_i.awaddr == spmv_pkg::REG_HEADER) begin
      word_o.is_header           = 1'b1;
      word_o.payload.hdr.row_len = axil_req_i.wdata[spmv_pkg::COL_W-1:0];
    end else begin
      word_o.payload.ent.col   = axil_req_i.wdata[spmv_pkg::ENT_COL_LSB +: spmv_pkg::COL_W];
      word_o.payload.ent.value = axil_req_i.wdata[spmv_pkg::ENT_VAL_LSB +: spmv_pkg::DATA_W];
    end
  end

  // write response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (axil_req_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // auto-incrementing weight address that wraps at the end of the vector
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      waddr_q <= '0;
    end else if (wr_fire && (axil_req_i.awaddr == spmv_pkg::REG_WADDR)) begin
      waddr_q <= axil_req_i.wdata[spmv_pkg::COL_W-1:0];
    end else if (w_we_o) begin
      if (waddr_q == spmv_pkg::COL_W'(DOT_SIZE - 1)) begin
        waddr_q <= '0;
      end else begin
        waddr_q <= waddr_q + 1'b1;
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    case (axil_req_i.araddr)
      spmv_pkg::REG_WADDR: begin
        rd_mux[spmv_pkg::COL_W-1:0] = waddr_q;
      end
      spmv_pkg::REG_STATUS: begin
        rd_mux[spmv_pkg::STAT_RES_VALID] = res_vld_q;
        rd_mux[spmv_pkg::STAT_FIFO_FULL] = fifo_full_i;
      end
      spmv_pkg::REG_RESULT: begin
        rd_mux[spmv_pkg::DATA_W-1:0] = res_q;
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  // read channel returns data one cycle after AR
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rd_mux;
    end
  end

  // one-deep result holder
  assign res_ready_o = !res_vld_q;

  // a result arriving while empty is kept even if RESULT is read in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_vld_q <= 1'b0;
    end else if (res_valid_i && res_ready_o) begin
      res_vld_q <= 1'b1;
    end else if (rd_fire && (axil_req_i.araddr == spmv_pkg::REG_RESULT)) begin
      res_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid_i && res_ready_o) begin
      res_q <= res_data_i;
    end
  end

endmodule

// File: csr_fifo.sv
`timescale 1ns/10ps
module csr_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_i,
  input  spmv_pkg::csr_word_t data_i,
  input  logic                pop_i,
  output spmv_pkg::csr_word_t data_o,
  output logic                full_o,
  output logic                empty_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  spmv_pkg::csr_word_t mem [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q;
  logic [PTR_W-1:0]    rd_ptr_q;
  logic [CNT_W-1:0]    count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // fall-through read keeps the head word visible
  assign data_o = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: weight_ram.sv
`timescale 1ns/10ps
module weight_ram #(
  parameter int DOT_SIZE = 1433
) (
  input  logic                        clk,
  input  logic                        we_i,
  input  logic [spmv_pkg::COL_W-1:0]  waddr_i,
  input  logic [spmv_pkg::DATA_W-1:0] wdata_i,
  input  logic [spmv_pkg::COL_W-1:0]  raddr_i,
  output logic [spmv_pkg::DATA_W-1:0] rdata_o
);

  logic [spmv_pkg::DATA_W-1:0] mem [DOT_SIZE];
  logic [spmv_pkg::DATA_W-1:0] rdata_q;

  // host write port
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read with data one cycle after the address
  always_ff @(posedge clk) begin
    rdata_q <= mem[raddr_i];
  end

  assign rdata_o = rdata_q;

endmodule

// File: sparse_pe.sv
`timescale 1ns/10ps
module sparse_pe (
  input  logic                        clk,
  input  logic                        rst_n,
  input  spmv_pkg::csr_word_t         word_i,
  input  logic                        empty_i,
  output logic                        pop_o,
  output logic [spmv_pkg::COL_W-1:0]  w_raddr_o,
  input  logic [spmv_pkg::DATA_W-1:0] w_rdata_i,
  output logic                        res_valid_o,
  output logic [spmv_pkg::DATA_W-1:0] res_data_o,
  input  logic                        res_ready_i
);

  localparam int DW = spmv_pkg::DATA_W;

  // partial sum must stay within -127..+127
  localparam logic signed [DW:0] SUM_MAX = (DW + 1)'(2 ** (DW - 1) - 1);
  localparam logic signed [DW:0] SUM_MIN = -SUM_MAX;

  logic                          pop_hdr;
  logic                          pop_ent;
  logic [spmv_pkg::COL_W-1:0]    rem_q;
  logic                          s1_vld_q;
  logic                          s1_last_q;
  logic [DW-1:0]                 s1_val_q;
  logic signed [2*DW-1:0]        prod_full;
  logic signed [DW:0]            prod;
  logic signed [DW:0]            sum_ext;
  logic                          sum_ovf;
  logic [DW-1:0]                 sum_next;
  logic [DW-1:0]                 sum_q;
  logic                          res_vld_q;

  // hold off while the row result is still in the pipe or not taken
  assign pop_o   = !empty_i && !res_vld_q && !s1_last_q;
  assign pop_hdr = pop_o && word_i.is_header;
  assign pop_ent = pop_o && !word_i.is_header;

  // column goes straight to the weight memory
  assign w_raddr_o = word_i.payload.ent.col;

  // product >>> 7 kept in nine bits since -128 * -128 gives +128
  assign prod_full = $signed(s1_val_q) * $signed(w_rdata_i);
  assign prod      = prod_full[2*DW-1:DW-1];

  assign sum_ext = $signed({sum_q[DW-1], sum_q}) + prod;
  assign sum_ovf = (sum_ext > SUM_MAX) || (sum_ext < SUM_MIN);

  // halve on overflow instead of wrapping
  assign sum_next = sum_ovf ? sum_ext[DW:1] : sum_ext[DW-1:0];

  assign res_valid_o = res_vld_q;
  assign res_data_o  = sum_q;

  // control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rem_q     <= '0;
      s1_vld_q  <= 1'b0;
      s1_last_q <= 1'b0;
      res_vld_q <= 1'b0;
    end else begin
      s1_vld_q  <= pop_ent;
      s1_last_q <= pop_ent && (rem_q == spmv_pkg::COL_W'(1));

      if (pop_hdr) begin
        rem_q <= word_i.payload.hdr.row_len;
      end else if (pop_ent) begin
        rem_q <= rem_q - 1'b1;
      end

      // empty row finishes right after its header
      if (pop_hdr && (word_i.payload.hdr.row_len == '0)) begin
        res_vld_q <= 1'b1;
      end else if (s1_last_q) begin
        res_vld_q <= 1'b1;
      end else if (res_ready_i) begin
        res_vld_q <= 1'b0;
      end
    end
  end

  // value waits one cycle for its weight
  always_ff @(posedge clk) begin
    if (pop_ent) begin
      s1_val_q <= word_i.payload.ent.value;
    end
  end

  // partial sum cleared by each header
  always_ff @(posedge clk) begin
    if (pop_hdr) begin
      sum_q <= '0;
    end else if (s1_vld_q) begin
      sum_q <= sum_next;
    end
  end

endmodule

// File: spmv_top.sv
`timescale 1ns/10ps
module spmv_top #(
  parameter int DOT_SIZE   = 1433,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  spmv_pkg::axil_req_t axil_req_i,
  output spmv_pkg::axil_rsp_t axil_rsp_o
);

  logic                        w_we;
  logic [spmv_pkg::COL_W-1:0]  w_waddr;
  logic [spmv_pkg::DATA_W-1:0] w_wdata;
  logic [spmv_pkg::COL_W-1:0]  w_raddr;
  logic [spmv_pkg::DATA_W-1:0] w_rdata;
  spmv_pkg::csr_word_t         push_word;
  spmv_pkg::csr_word_t         head_word;
  logic                        push;
  logic                        pop;
  logic                        fifo_full;
  logic                        fifo_empty;
  logic                        res_valid;
  logic [spmv_pkg::DATA_W-1:0] res_data;
  logic                        res_ready;

  spmv_host_port #(
    .DOT_SIZE (DOT_SIZE)
  ) u_host_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .w_we_o      (w_we),
    .w_addr_o    (w_waddr),
    .w_data_o    (w_wdata),
    .word_o      (push_word),
    .push_o      (push),
    .fifo_full_i (fifo_full),
    .res_valid_i (res_valid),
    .res_data_i  (res_data),
    .res_ready_o (res_ready)
  );

  csr_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (push),
    .data_i  (push_word),
    .pop_i   (pop),
    .data_o  (head_word),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  weight_ram #(
    .DOT_SIZE (DOT_SIZE)
  ) u_weight_ram (
    .clk     (clk),
    .we_i    (w_we),
    .waddr_i (w_waddr),
    .wdata_i (w_wdata),
    .raddr_i (w_raddr),
    .rdata_o (w_rdata)
  );

  sparse_pe u_pe (
    .clk         (clk),
    .rst_n       (rst_n),
    .word_i      (head_word),
    .empty_i     (fifo_empty),
    .pop_o       (pop),
    .w_raddr_o   (w_raddr),
    .w_rdata_i   (w_rdata),
    .res_valid_o (res_valid),
    .res_data_o  (res_data),
    .res_ready_i (res_ready)
  );

endmodule

// File: spmv_tb.sv
`timescale 1ns/10ps
module spmv_tb;

  localparam int DOT_SIZE   = 1433;
  localparam int FIFO_DEPTH = 8;
  localparam int DENSE_ROWS = 4;
  localparam int DENSE_LEN  = 8;
  localparam int BP_ROWS    = 20;
  localparam int BP_LEN     = 6;
  localparam int RAND_ROWS  = 10;
  localparam int RAND_LEN   = 12;
  // upper bound of host writes over two weight loads, spot weights and all rows
  localparam int PUSHED_WORDS = 2 * (DOT_SIZE + 1) + 4 + DENSE_ROWS * (DENSE_LEN + 1) + 15 + 3 +
                                BP_ROWS * (BP_LEN + 1) + RAND_ROWS * (RAND_LEN + 1);
  localparam int TIMEOUT = 20 * PUSHED_WORDS + 2000;

  logic                clk;
  logic                rst_n;
  spmv_pkg::axil_req_t axil_req;
  spmv_pkg::axil_rsp_t axil_rsp;
  int                  cycles;
  int                  w_model [DOT_SIZE];
  logic [7:0]          exp_q [$];

  spmv_top #(
    .DOT_SIZE   (DOT_SIZE),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      abort_run($sformatf("simulation timed out after %0d cycles", TIMEOUT));
    end
  end

  // responses must stay up until the master takes them
  bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else abort_run("write response dropped before it was accepted");

  rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else abort_run("read response dropped before it was accepted");

  // full FIFO must hold off header and entry writes on both AW and W
  stream_stall: assert property (@(posedge clk) disable iff (!rst_n)
    i_dut.fifo_full && axil_req.awvalid &&
    (axil_req.awaddr == spmv_pkg::REG_HEADER || axil_req.awaddr == spmv_pkg::REG_ENTRY)
    |-> !axil_rsp.awready && !axil_rsp.wready)
    else abort_run("stream write accepted while the FIFO was full");

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    do @(negedge clk); while (!(axil_rsp.awready && axil_rsp.wready));
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    do @(negedge clk); while (!axil_rsp.bvalid);
    // random ready delay so bvalid has to hold
    repeat ($urandom_range(0, 2)) @(posedge clk);
    @(posedge clk);
    axil_req.bready <= 1'b1;
    @(posedge clk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    do @(negedge clk); while (!axil_rsp.arready);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    do @(negedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    repeat ($urandom_range(0, 2)) @(posedge clk);
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    axil_req.rready <= 1'b0;
  endtask

  task automatic load_weights(input bit random_fill);
    axil_write(spmv_pkg::REG_WADDR, 32'd0);
    for (int i = 0; i < DOT_SIZE; i++) begin
      w_model[i] = random_fill ? int'($urandom_range(0, 255)) - 128 : (i % 13) + 1;
      axil_write(spmv_pkg::REG_WDATA, 32'(w_model[i] & 255));
    end
  endtask

  task automatic set_weight(input int addr, input int value);
    w_model[addr] = value;
    axil_write(spmv_pkg::REG_WADDR, 32'(addr));
    axil_write(spmv_pkg::REG_WDATA, 32'(value & 255));
  endtask

  // expected sum of products shifted right by 7 and halved whenever outside -127..127
  task automatic send_row(input int cols[$], input int vals[$]);
    int sum;
    int s;
    sum = 0;
    foreach (cols[k]) begin
      s = sum + ((vals[k] * w_model[cols[k]]) >>> 7);
      sum = (s > 127 || s < -127) ? (s >>> 1) : s;
    end
    exp_q.push_back(8'(sum));
    axil_write(spmv_pkg::REG_HEADER, 32'(cols.size()));
    foreach (cols[k]) begin
      axil_write(spmv_pkg::REG_ENTRY, {5'd0, 11'(cols[k]), 8'd0, 8'(vals[k])});
    end
  endtask

  task automatic random_row(input int len, input int lo, input int hi);
    int cols[$];
    int vals[$];
    for (int k = 0; k < len; k++) begin
      cols.push_back(int'($urandom_range(0, DOT_SIZE - 1)));
      vals.push_back(int'($urandom_range(0, hi - lo)) + lo);
    end
    send_row(cols, vals);
  endtask

  task automatic read_result(input bit check_clear);
    logic [31:0] d;
    logic [7:0]  expected;
    do axil_read(spmv_pkg::REG_STATUS, d); while (!d[0]);
    axil_read(spmv_pkg::REG_RESULT, d);
    expected = exp_q.pop_front();
    assert (d[7:0] == expected) else abort_run($sformatf(
      "** Error at %0d ns: row result %0d, expected %0d", $time, $signed(d[7:0]),
      $signed(expected)));
    if (check_clear) begin
      axil_read(spmv_pkg::REG_STATUS, d);
      assert (!d[0]) else abort_run($sformatf(
        "** Error at %0d ns: result valid still set after result read", $time));
    end
  endtask

  initial begin
    int          cols[$];
    int          vals[$];
    logic [31:0] d;
    void'($urandom(96522));
    cycles   = 0;
    rst_n    = 1'b0;
    axil_req = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // small positive weights and values without overflow
    load_weights(1'b0);
    for (int r = 0; r < DENSE_ROWS; r++) begin
      random_row(DENSE_LEN, 1, 40);
      read_result(1'b1);
    end

    // large same-sign products in both directions
    set_weight(0, 127);
    set_weight(1, -128);
    cols = {0, 0, 0, 0};
    vals = {127, 127, 127, 127};
    send_row(cols, vals);
    read_result(1'b1);
    cols = {0, 0, 0};
    vals = {-128, -128, -128};
    send_row(cols, vals);
    read_result(1'b1);
    cols = {1, 1, 1};
    send_row(cols, vals);
    read_result(1'b1);

    // empty row then a single entry
    cols.delete();
    vals.delete();
    send_row(cols, vals);
    read_result(1'b1);
    random_row(1, -100, 100);
    read_result(1'b1);

    // results left unread until the FIFO backs up
    fork
      begin
        for (int r = 0; r < BP_ROWS; r++) begin
          random_row($urandom_range(1, BP_LEN), -128, 127);
        end
      end
      begin
        do axil_read(spmv_pkg::REG_STATUS, d); while (!d[1]);
        repeat (10) @(posedge clk);
        for (int r = 0; r < BP_ROWS; r++) begin
          read_result(1'b0);
        end
      end
    join

    load_weights(1'b1);
    for (int r = 0; r < RAND_ROWS; r++) begin
      random_row($urandom_range(1, RAND_LEN), -128, 127);
      read_result(1'b1);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// File: spmv_top.f
spmv_pkg.sv
spmv_host_port.sv
csr_fifo.sv
weight_ram.sv
sparse_pe.sv
spmv_top.sv
spmv_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module spmv_tb -f spmv_top.f \
  -o spmv_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/spmv_sim > sim.log 2>&1
cat sim.log
grep -q "Regression passed" sim.log && exit 0 || exit 1
